/* bench/alu_rs_golden.txt */
# D slot op a a_rdy a_tag b b_rdy b_tag dest expected, all hex
# C tag data, W idle cycles, F flush, H grant hold, S slot_ready, E drain
D 0 0 00000005 1 0 00000007 1 0 1 0000000c
D 1 1 00000003 1 0 00000005 1 0 2 fffffffe
D 0 7 80000000 1 0 00000004 1 0 3 f8000000
D 1 8 ffffffff 1 0 00000001 1 0 4 00000001
D 0 9 ffffffff 1 0 00000001 1 0 5 00000000
D 1 5 00000001 1 0 0000003f 1 0 6 80000000
W 4
D 0 6 80000000 1 0 00000021 1 0 7 40000000
D 1 4 f0f0f0f0 1 0 ff00ff00 1 0 8 0ff00ff0
D 0 2 12345678 1 0 0000ffff 1 0 9 00005678
D 1 3 12340000 1 0 00005678 1 0 a 12345678
W 6
D 0 0 00000000 0 c 00000010 1 0 b 00000110
C c 00000100
W 2
D 0 1 00000000 0 d 00000000 0 e 0 00000003
C d 00000010
C e 0000000d
W 4
E
H 1
D 0 0 00000001 1 0 00000001 1 0 1 00000002
D 1 3 000000f0 1 0 0000000f 1 0 2 000000ff
D 0 8 00000005 1 0 fffffffb 1 0 3 00000000
D 1 7 7fffffff 1 0 0000001f 1 0 4 00000000
W 3
S 0
H 0
E
H 1
D 0 0 00000001 1 0 00000002 1 0 5 00000003
D 1 0 00000000 0 c 00000001 1 0 6 00000001
W 2
F
H 0
C c 00000001
D 0 4 aaaaaaaa 1 0 55555555 1 0 7 ffffffff
D 1 1 00000000 1 0 00000001 1 0 8 ffffffff
D 0 8 80000000 1 0 7fffffff 1 0 9 00000001
D 1 9 80000000 1 0 7fffffff 1 0 a 00000000
W 2

/* bench/alu_rs_tb.sv */
module alu_rs_tb
	import rs_config_pkg::*, cpu_types_pkg::*;
;

	localparam int n_tags = 1 << rob_tag_w;
	localparam int wait_limit = 200;

	logic clk;
	logic rst;
	logic flush;
	logic [1:0] slot_ready;
	logic [1:0] taken;
	alu_op_t [1:0] disp_op;
	word_t [1:0][1:0] disp_src_val;
	logic [1:0][1:0] disp_src_rdy;
	rob_tag_t [1:0][1:0] disp_src_tag;
	rob_tag_t [1:0] disp_dest;
	logic cdb_valid;
	rob_tag_t cdb_tag;
	word_t cdb_data;
	logic res_valid;
	rob_tag_t res_tag;
	word_t res_data;
	logic res_grant;

	// reference model indexed by rob tag
	logic live [n_tags];
	alu_op_t m_op [n_tags];
	word_t m_val [n_tags][2];
	logic m_rdy [n_tags][2];
	rob_tag_t m_src [n_tags][2];
	word_t m_gold [n_tags];

	int mismatches;
	int timeouts;
	int faults;
	logic aborted;
	int dispatched;
	int retired;
	logic hold;
	logic [31:0] lfsr;
	logic stall;
	rob_tag_t held_tag;
	word_t held_data;

	alu_rs_top dut (
		.clk          (clk),
		.rst          (rst),
		.flush        (flush),
		.slot_ready   (slot_ready),
		.taken        (taken),
		.disp_op      (disp_op),
		.disp_src_val (disp_src_val),
		.disp_src_rdy (disp_src_rdy),
		.disp_src_tag (disp_src_tag),
		.disp_dest    (disp_dest),
		.cdb_valid    (cdb_valid),
		.cdb_tag      (cdb_tag),
		.cdb_data     (cdb_data),
		.res_valid    (res_valid),
		.res_tag      (res_tag),
		.res_data     (res_data),
		.res_grant    (res_grant)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
		case (op)
			op_add: return a + b;
			op_sub: return a - b;
			op_and: return a & b;
			op_or: return a | b;
			op_xor: return a ^ b;
			op_sll: return a << b[4:0];
			op_srl: return a >> b[4:0];
			op_sra: return $signed(a) >>> b[4:0];
			op_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			op_sltu: return (a < b) ? 32'd1 : 32'd0;
			default: return '0;
		endcase
	endfunction

	function automatic int live_count();
		int n;
		n = 0;
		for (int t = 0; t < n_tags; t++) begin
			if (live[t]) n++;
		end
		return n;
	endfunction

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_tag(input rob_tag_t got, input rob_tag_t exp, input string what);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			mismatches++;
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic finish_run();
		$display("closing: %0d mismatches, %0d timeouts, %0d other failures",
			mismatches, timeouts, faults);
		if (mismatches + timeouts + faults == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		aborted = 1'b1;
		$display("timeout at %0t: gave up waiting for %s", $time, what);
	endtask

	// end the current cycle and set up the grant of the next
	task automatic next_cycle();
		@(negedge clk);
		taken = '0;
		cdb_valid = 1'b0;
		if (hold) begin
			res_grant = 1'b0;
		end else begin
			res_grant = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic commit();
		if (|taken || cdb_valid) next_cycle();
	endtask

	task automatic check_golden(input int t);
		if (m_rdy[t][0] && m_rdy[t][1])
			check_word(alu_ref(m_op[t], m_val[t][0], m_val[t][1]), m_gold[t], "golden value");
	endtask

	task automatic drain();
		int cnt;
		cnt = 0;
		commit();
		while (live_count() > 0 && !aborted) begin
			next_cycle();
			cnt++;
			if (cnt > wait_limit) report_timeout("outstanding results to retire");
		end
	endtask

	// retirement and output stability under back-pressure
	always @(posedge clk) begin
		if (rst) begin
			stall = 1'b0;
		end else begin
			if (stall) begin
				check_count(int'(res_valid), 1, "res_valid while stalled");
				check_tag(res_tag, held_tag, "res_tag while stalled");
				check_word(res_data, held_data, "res_data while stalled");
			end
			if (res_valid && res_grant) begin
				check_count(int'(live[res_tag]), 1, "retired tag outstanding");
				if (live[res_tag]) begin
					check_count(int'(m_rdy[res_tag][0] && m_rdy[res_tag][1]), 1,
						"operands present at retire");
					check_word(res_data, alu_ref(m_op[res_tag], m_val[res_tag][0],
						m_val[res_tag][1]), "res_data");
					live[res_tag] = 1'b0;
					retired++;
				end
			end
			stall = res_valid && !res_grant && !flush;
			held_tag = res_tag;
			held_data = res_data;
		end
	end

	initial begin
		int fd;
		int cnt;
		int n;
		string line;
		string kind;
		logic [31:0] f [10];

		rst = 1'b1;
		flush = 1'b0;
		taken = '0;
		disp_op = {op_add, op_add};
		disp_src_val = '0;
		disp_src_rdy = '0;
		disp_src_tag = '0;
		disp_dest = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		res_grant = 1'b0;
		hold = 1'b0;
		lfsr = 32'h95b0;
		mismatches = 0;
		timeouts = 0;
		faults = 0;
		aborted = 1'b0;
		dispatched = 0;
		retired = 0;
		for (int t = 0; t < n_tags; t++) live[t] = 1'b0;
		repeat (10) @(negedge clk);
		rst = 1'b0;

		fd = $fopen("bench/alu_rs_golden.txt", "r");
		if (fd == 0) begin
			faults++;
			aborted = 1'b1;
			$display("could not open the golden file bench/alu_rs_golden.txt");
		end
		while (!aborted && !$feof(fd)) begin
			n = $fgets(line, fd);
			if (n < 2 || line.substr(0, 0) == "#") continue;
			n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", kind, f[0], f[1], f[2],
				f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
			case (kind)
				"D": begin
					if (taken[f[0][0]]) next_cycle();
					cnt = 0;
					while (!slot_ready[f[0][0]] && !aborted) begin
						next_cycle();
						cnt++;
						if (cnt > wait_limit) report_timeout("slot_ready");
					end
					if (!aborted) begin
						disp_op[f[0][0]] = alu_op_t'(f[1][3:0]);
						disp_src_val[f[0][0]] = {f[5], f[2]};
						disp_src_rdy[f[0][0]] = {f[6][0], f[3][0]};
						disp_src_tag[f[0][0]] = {rob_tag_t'(f[7]), rob_tag_t'(f[4])};
						disp_dest[f[0][0]] = rob_tag_t'(f[8]);
						taken[f[0][0]] = 1'b1;
						live[f[8]] = 1'b1;
						m_op[f[8]] = alu_op_t'(f[1][3:0]);
						m_val[f[8]][0] = f[2];
						m_val[f[8]][1] = f[5];
						m_rdy[f[8]][0] = f[3][0];
						m_rdy[f[8]][1] = f[6][0];
						m_src[f[8]][0] = rob_tag_t'(f[4]);
						m_src[f[8]][1] = rob_tag_t'(f[7]);
						m_gold[f[8]] = f[9];
						dispatched++;
						check_golden(f[8]);
					end
				end
				"C": begin
					if (cdb_valid) next_cycle();
					cdb_valid = 1'b1;
					cdb_tag = rob_tag_t'(f[0]);
					cdb_data = f[1];
					for (int t = 0; t < n_tags; t++) begin
						for (int j = 0; j < 2; j++) begin
							if (live[t] && !m_rdy[t][j] && m_src[t][j] == rob_tag_t'(f[0])) begin
								m_val[t][j] = f[1];
								m_rdy[t][j] = 1'b1;
								check_golden(t);
							end
						end
					end
				end
				"W": begin
					commit();
					repeat (f[0]) next_cycle();
				end
				"F": begin
					commit();
					flush = 1'b1;
					res_grant = 1'b0;
					for (int t = 0; t < n_tags; t++) begin
						if (live[t]) dispatched--;
						live[t] = 1'b0;
					end
					next_cycle();
					flush = 1'b0;
					check_count(int'(res_valid), 0, "res_valid after flush");
					check_count(int'(slot_ready), 3, "slot_ready after flush");
				end
				"H": hold = f[0][0];
				"S": begin
					commit();
					check_count(int'(slot_ready), int'(f[0]), "slot_ready");
				end
				"E": drain();
				default: begin
					faults++;
					$display("unknown record in golden file: %s", line);
				end
			endcase
		end
		if (fd != 0) $fclose(fd);
		hold = 1'b0;
		drain();
		if (!aborted) check_count(retired, dispatched, "retired tag count");
		finish_run();
	end

endmodule

/* design/alu.sv */
module alu
	import cpu_types_pkg::*;
(
	input  alu_op_t op,
	input  word_t   a,
	input  word_t   b,
	output word_t   y
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			op_add: begin
				y = a + b;
			end
			op_sub: begin
				y = a - b;
			end
			op_and: begin
				y = a & b;
			end
			op_or: begin
				y = a | b;
			end
			op_xor: begin
				y = a ^ b;
			end
			op_sll: begin
				y = a << shamt;
			end
			op_srl: begin
				y = a >> shamt;
			end
			op_sra: begin
				y = word_t'($signed(a) >>> shamt);
			end
			op_slt: begin
				y = word_t'($signed(a) < $signed(b));
			end
			op_sltu: begin
				y = word_t'(a < b);
			end
			default: begin
				y = '0;
			end
		endcase
	end

endmodule

/* design/alu_rs_top.sv */
module alu_rs_top
	import rs_config_pkg::*, cpu_types_pkg::*;
(
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 flush,
	output logic     [dispatch_width-1:0]        slot_ready,
	input  logic     [dispatch_width-1:0]        taken,
	input  alu_op_t  [dispatch_width-1:0]        disp_op,
	input  word_t    [dispatch_width-1:0][1:0]   disp_src_val,
	input  logic     [dispatch_width-1:0][1:0]   disp_src_rdy,
	input  rob_tag_t [dispatch_width-1:0][1:0]   disp_src_tag,
	input  rob_tag_t [dispatch_width-1:0]        disp_dest,
	input  logic                                 cdb_valid,
	input  rob_tag_t                             cdb_tag,
	input  word_t                                cdb_data,
	output logic                                 res_valid,
	output rob_tag_t                             res_tag,
	output word_t                                res_data,
	input  logic                                 res_grant
);

	logic [rs_size-1:0] busy;
	logic [rs_size-1:0] ack;
	logic [rs_size-1:0] write_en;
	logic [rs_size-1:0] write_sel;
	logic [rs_size-1:0] entry_ready;
	rob_tag_t [rs_size-1:0] dest;
	word_t [rs_size-1:0] result;

	rs_alloc u_alloc (
		.clk        (clk),
		.rst        (rst),
		.flush      (flush),
		.taken      (taken),
		.busy       (busy),
		.ack        (ack),
		.slot_ready (slot_ready),
		.write_en   (write_en),
		.write_sel  (write_sel)
	);

	for (genvar i = 0; i < rs_size; i++) begin : gen_entry
		rs_entry u_entry (
			.clk          (clk),
			.rst          (rst),
			.flush        (flush),
			.write_en     (write_en[i]),
			.write_sel    (write_sel[i]),
			.ack          (ack[i]),
			.disp_op      (disp_op),
			.disp_src_val (disp_src_val),
			.disp_src_rdy (disp_src_rdy),
			.disp_src_tag (disp_src_tag),
			.disp_dest    (disp_dest),
			.cdb_valid    (cdb_valid),
			.cdb_tag      (cdb_tag),
			.cdb_data     (cdb_data),
			.busy         (busy[i]),
			.entry_ready  (entry_ready[i]),
			.dest         (dest[i]),
			.result       (result[i])
		);
	end

	result_arbiter u_arbiter (
		.clk         (clk),
		.rst         (rst),
		.flush       (flush),
		.entry_ready (entry_ready),
		.dest        (dest),
		.result      (result),
		.res_grant   (res_grant),
		.res_valid   (res_valid),
		.res_tag     (res_tag),
		.res_data    (res_data),
		.ack         (ack)
	);

endmodule

/* design/cpu_types_pkg.sv */
package cpu_types_pkg;
	import rs_config_pkg::*;

	// entry number inside the station
	typedef logic [rs_index_w-1:0] rs_index_t;

	// producer or destination tag in the reorder buffer
	typedef logic [rob_tag_w-1:0] rob_tag_t;

	typedef logic [31:0] word_t;

	typedef enum logic [3:0] {
		op_add  = 4'd0,
		op_sub  = 4'd1,
		op_and  = 4'd2,
		op_or   = 4'd3,
		op_xor  = 4'd4,
		op_sll  = 4'd5,
		op_srl  = 4'd6,
		op_sra  = 4'd7,
		op_slt  = 4'd8,
		op_sltu = 4'd9
	} alu_op_t;

endpackage

/* design/result_arbiter.sv */
module result_arbiter
	import rs_config_pkg::*, cpu_types_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     flush,
	input  logic     [rs_size-1:0]   entry_ready,
	input  rob_tag_t [rs_size-1:0]   dest,
	input  word_t    [rs_size-1:0]   result,
	input  logic                     res_grant,
	output logic                     res_valid,
	output rob_tag_t                 res_tag,
	output word_t                    res_data,
	output logic     [rs_size-1:0]   ack
);

	rs_index_t ptr_q;
	rs_index_t sel;
	rs_index_t idx;
	rs_index_t sel_next;
	logic found;

	// first ready entry at or after the pointer
	always_comb begin
		found = 1'b0;
		sel = ptr_q;
		for (int k = 0; k < rs_size; k++) begin
			idx = rs_index_t'((int'(ptr_q) + k) % rs_size);
			if (entry_ready[idx] && !found) begin
				found = 1'b1;
				sel = idx;
			end
		end
	end

	assign res_valid = found;
	assign res_tag = dest[sel];
	assign res_data = result[sel];

	always_comb begin
		ack = '0;
		ack[sel] = found && res_grant;
	end

	assign sel_next = (sel == rs_index_t'(rs_size - 1)) ? '0 : sel + 1'b1;

	// parking on a stalled entry keeps the output stable
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			ptr_q <= '0;
		end else if (found) begin
			ptr_q <= res_grant ? sel_next : sel;
		end
	end

	// a stalled result stays on the same entry
	a_stall_hold: assert property (@(posedge clk) disable iff (rst)
		res_valid && !res_grant && !flush |=> res_valid && sel == $past(sel));

endmodule

/* design/rs_alloc.sv */
module rs_alloc
	import rs_config_pkg::*, cpu_types_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      flush,
	input  logic [dispatch_width-1:0] taken,
	input  logic [rs_size-1:0]        busy,
	input  logic [rs_size-1:0]        ack,
	output logic [dispatch_width-1:0] slot_ready,
	output logic [rs_size-1:0]        write_en,
	output logic [rs_size-1:0]        write_sel
);

	rs_index_t [dispatch_width-1:0] slot_idx_q;
	rs_index_t [dispatch_width-1:0] slot_idx_n;
	logic [dispatch_width-1:0] slot_ready_n;
	logic [rs_size-1:0] busy_n;

	// decode the taken strobes onto the entries
	always_comb begin
		for (int i = 0; i < rs_size; i++) begin
			write_en[i] = (taken[0] && slot_idx_q[0] == rs_index_t'(i)) ||
				(taken[1] && slot_idx_q[1] == rs_index_t'(i));
			write_sel[i] = taken[1] && slot_idx_q[1] == rs_index_t'(i);
		end
	end

	assign busy_n = (busy & ~ack) | write_en;

	// lowest and second lowest free entry of next cycle
	always_comb begin
		slot_ready_n = '0;
		slot_idx_n = '0;
		for (int i = 0; i < rs_size; i++) begin
			if (!busy_n[i] && !slot_ready_n[0]) begin
				slot_ready_n[0] = 1'b1;
				slot_idx_n[0] = rs_index_t'(i);
			end else if (!busy_n[i] && !slot_ready_n[1]) begin
				slot_ready_n[1] = 1'b1;
				slot_idx_n[1] = rs_index_t'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			slot_ready <= 2'b11;
			slot_idx_q[0] <= rs_index_t'(0);
			slot_idx_q[1] <= rs_index_t'(1);
		end else begin
			slot_ready <= slot_ready_n;
			slot_idx_q <= slot_idx_n;
		end
	end

	// dispatcher must only take an offered slot
	a_taken_offered: assert property (@(posedge clk) disable iff (rst)
		(taken & ~slot_ready) == '0);

endmodule

/* design/rs_config_pkg.sv */
package rs_config_pkg;

	// station geometry
	localparam int rs_size = 4;
	localparam int dispatch_width = 2;

	// entry number width covering rs_size
	localparam int rs_index_w = 2;

	// reorder buffer tag width
	localparam int rob_tag_w = 4;

endpackage

/* design/rs_entry.sv */
module rs_entry
	import rs_config_pkg::*, cpu_types_pkg::*;
(
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 flush,
	input  logic                                 write_en,
	input  logic                                 write_sel,
	input  logic                                 ack,
	input  alu_op_t  [dispatch_width-1:0]        disp_op,
	input  word_t    [dispatch_width-1:0][1:0]   disp_src_val,
	input  logic     [dispatch_width-1:0][1:0]   disp_src_rdy,
	input  rob_tag_t [dispatch_width-1:0][1:0]   disp_src_tag,
	input  rob_tag_t [dispatch_width-1:0]        disp_dest,
	input  logic                                 cdb_valid,
	input  rob_tag_t                             cdb_tag,
	input  word_t                                cdb_data,
	output logic                                 busy,
	output logic                                 entry_ready,
	output rob_tag_t                             dest,
	output word_t                                result
);

	logic busy_q;
	alu_op_t op_q;
	rob_tag_t dest_q;
	word_t [1:0] val_q;
	word_t [1:0] val_n;
	logic [1:0] rdy_q;
	logic [1:0] rdy_n;
	rob_tag_t [1:0] tag_q;
	rob_tag_t [1:0] tag_n;

	// operand load with CDB wakeup in the dispatch cycle too
	always_comb begin
		for (int j = 0; j < 2; j++) begin
			val_n[j] = val_q[j];
			rdy_n[j] = rdy_q[j];
			tag_n[j] = tag_q[j];
			if (write_en) begin
				val_n[j] = disp_src_val[write_sel][j];
				rdy_n[j] = disp_src_rdy[write_sel][j];
				tag_n[j] = disp_src_tag[write_sel][j];
			end
			if ((write_en || busy_q) && cdb_valid && !rdy_n[j] && tag_n[j] == cdb_tag) begin
				val_n[j] = cdb_data;
				rdy_n[j] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			busy_q <= 1'b0;
			rdy_q <= '0;
		end else begin
			busy_q <= write_en || (busy_q && !ack);
			rdy_q <= rdy_n;
		end
	end

	always_ff @(posedge clk) begin
		val_q <= val_n;
		tag_q <= tag_n;
		if (write_en) begin
			op_q <= disp_op[write_sel];
			dest_q <= disp_dest[write_sel];
		end
	end

	alu u_alu (
		.op (op_q),
		.a  (val_q[0]),
		.b  (val_q[1]),
		.y  (result)
	);

	assign busy = busy_q;
	assign entry_ready = busy_q && rdy_q[0] && rdy_q[1];
	assign dest = dest_q;

	// allocator only points at free entries
	a_write_free: assert property (@(posedge clk) disable iff (rst)
		write_en |-> !busy_q);

	// arbiter only acks a finished entry
	a_ack_ready: assert property (@(posedge clk) disable iff (rst)
		ack |-> entry_ready);

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f --top-module alu_rs_tb -o alu_rs_sim
out="$(./obj_dir/alu_rs_sim)"
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
	exit 0
fi
exit 1

/* vlog.f */
design/rs_config_pkg.sv
design/cpu_types_pkg.sv
design/alu.sv
design/rs_alloc.sv
design/rs_entry.sv
design/result_arbiter.sv
design/alu_rs_top.sv
bench/alu_rs_tb.sv
